// File: design/video_config.svh
// video mode, framebuffer geometry and data widths
// shared by every RTL file and the testbench

`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// reduced mode for simulation, 64x48 active
// 640x480 alternative: 640/16/96/48 horizontal, 480/10/2/33 vertical
`define H_ACTIVE   64   // active pixels per line
`define H_FP       4    // horizontal front porch
`define H_SYNC     8    // horizontal sync width
`define H_BP       4    // horizontal back porch
`define V_ACTIVE   48   // active lines per frame
`define V_FP       1    // vertical front porch
`define V_SYNC     2    // vertical sync width
`define V_BP       3    // vertical back porch

`define CORDW      16   // screen coordinate width

`define FB_WIDTH   32   // framebuffer pixels per row
`define FB_HEIGHT  24   // framebuffer rows
`define FB_SCALE   2    // screen pixels per framebuffer pixel
`define FB_POSW    8    // framebuffer x or y width

`define CIDXW      4    // colour index width
`define CHANW      4    // colour channel width
`define PAL_DEPTH  16   // palette entries

`endif

// File: design/video_pkg.sv
// display-side types: screen coordinates and colour channels

`include "video_config.svh"

package video_pkg;

    // signed so blanking can sit at negative positions in other modes
    typedef logic signed [`CORDW-1:0] coord_t;

    // one channel of a 12-bit rgb pixel
    typedef logic [`CHANW-1:0] chan_t;

endpackage

// File: design/fb_pkg.sv
// framebuffer-side types: colour index, address, position
// and the box drawer state encoding

`include "video_config.svh"

package fb_pkg;

    typedef logic [`CIDXW-1:0] cidx_t;   // palette index

    typedef logic [$clog2(`FB_WIDTH * `FB_HEIGHT)-1:0] fb_addr_t;

    typedef logic [`FB_POSW-1:0] fb_pos_t;   // framebuffer x or y

    typedef enum logic [2:0] {
        IDLE,
        WAIT_FRAME,   // hold off until start of frame
        CLEAR,        // fill with background index
        TOP,
        RIGHT,
        BOTTOM,
        LEFT
    } draw_state_t;

endpackage

// File: design/display_timings.sv
// display timing generator: pixel and line counters,
// negative syncs, data enable, frame and line strobes

`timescale 1ns/1ps
`include "video_config.svh"

module display_timings import video_pkg::*; (
    input  logic   clk_pix,
    input  logic   arst_n,
    output coord_t sx,      // horizontal position
    output coord_t sy,      // vertical position
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame,   // start of frame
    output logic   line     // start of line
);

    localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int HS_STA  = `H_ACTIVE + `H_FP;
    localparam int HS_END  = HS_STA + `H_SYNC - 1;
    localparam int VS_STA  = `V_ACTIVE + `V_FP;
    localparam int VS_END  = VS_STA + `V_SYNC - 1;

    coord_t sx_next;
    coord_t sy_next;

    // next counter position, active area first then blanking
    always_comb begin
        if (sx == coord_t'(H_TOTAL - 1)) begin
            sx_next = '0;
            if (sy == coord_t'(V_TOTAL - 1)) begin
                sy_next = '0;
            end else begin
                sy_next = coord_t'(sy + 1);
            end
        end else begin
            sx_next = coord_t'(sx + 1);
            sy_next = sy;
        end
    end

    // flags are decoded from the next position so they line up with sx/sy
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= coord_t'(H_TOTAL - 1);   // park in back porch
            sy    <= coord_t'(V_TOTAL - 1);
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= !(sx_next >= HS_STA && sx_next <= HS_END);   // active low
            vsync <= !(sy_next >= VS_STA && sy_next <= VS_END);
            de    <= (sx_next < `H_ACTIVE) && (sy_next < `V_ACTIVE);
            frame <= (sx_next == 0) && (sy_next == 0);
            line  <= (sx_next == 0);
        end
    end

endmodule

// File: design/framebuffer.sv
// framebuffer: single-port colour index memory shared by display reads
// and drawer writes, scaled read addressing, palette and rgb output

`timescale 1ns/1ps
`include "video_config.svh"

module framebuffer import video_pkg::*, fb_pkg::*; (
    input  logic    clk_pix,
    input  logic    arst_n,
    // display position
    input  logic    de,
    input  coord_t  sx,
    input  coord_t  sy,
    // drawer write port
    input  logic    wr_valid,
    input  fb_pos_t wr_x,
    input  fb_pos_t wr_y,
    input  cidx_t   wr_cidx,
    output logic    wr_ready,
    // palette write port
    input  logic    pal_valid,
    input  cidx_t   pal_idx,
    input  chan_t   pal_r,
    input  chan_t   pal_g,
    input  chan_t   pal_b,
    output logic    pal_ready,
    // pixel colour, two cycles after de/sx/sy
    output chan_t   red,
    output chan_t   green,
    output chan_t   blue
);

    localparam int FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;

    cidx_t mem [FB_PIXELS];

    chan_t pal_mem_r [`PAL_DEPTH];
    chan_t pal_mem_g [`PAL_DEPTH];
    chan_t pal_mem_b [`PAL_DEPTH];

    logic     rd_en;
    logic     wr_fire;
    fb_pos_t  rd_x;
    fb_pos_t  rd_y;
    fb_addr_t rd_addr;
    fb_addr_t wr_addr;
    cidx_t    rd_cidx;   // fetched index, held across the scaled pair
    logic     de_p1;
    logic     rd_p1;

    // one fetch per scaled pixel pair, on the even column
    assign rd_en = de && !sx[0];

    // display owns the port whenever it reads
    assign wr_ready = !rd_en;
    assign wr_fire  = wr_valid && wr_ready;

    assign rd_x    = fb_pos_t'(sx / `FB_SCALE);
    assign rd_y    = fb_pos_t'(sy / `FB_SCALE);
    assign rd_addr = fb_addr_t'(rd_y * `FB_WIDTH + rd_x);
    assign wr_addr = fb_addr_t'(wr_y * `FB_WIDTH + wr_x);

    // single port: read or write, never both
    always_ff @(posedge clk_pix) begin
        if (rd_en) begin
            rd_cidx <= mem[rd_addr];
        end else if (wr_fire) begin
            mem[wr_addr] <= wr_cidx;
        end
    end

    // palette busy in the lookup cycle after a fetch
    assign pal_ready = !rd_p1;

    always_ff @(posedge clk_pix) begin
        if (pal_valid && pal_ready) begin
            pal_mem_r[pal_idx] <= pal_r;
            pal_mem_g[pal_idx] <= pal_g;
            pal_mem_b[pal_idx] <= pal_b;
        end
    end

    // stage 1 flags
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            de_p1 <= 1'b0;
            rd_p1 <= 1'b0;
        end else begin
            de_p1 <= de;
            rd_p1 <= rd_en;
        end
    end

    // stage 2: palette lookup, black outside the active area
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (de_p1) begin
            red   <= pal_mem_r[rd_cidx];
            green <= pal_mem_g[rd_cidx];
            blue  <= pal_mem_b[rd_cidx];
        end else begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

// File: design/box_drawer.sv
// box drawer FSM: clears the framebuffer to a background index,
// then traces a one-pixel border clockwise from the top left

`timescale 1ns/1ps
`include "video_config.svh"

module box_drawer import fb_pkg::*; (
    input  logic    clk_pix,
    input  logic    arst_n,
    input  logic    start,      // level, sampled in IDLE
    input  cidx_t   bg_cidx,
    input  cidx_t   box_cidx,
    input  logic    frame,
    output logic    busy,
    output logic    wr_valid,
    output fb_pos_t wr_x,
    output fb_pos_t wr_y,
    output cidx_t   wr_cidx,
    input  logic    wr_ready
);

    localparam fb_pos_t X_MAX = fb_pos_t'(`FB_WIDTH - 1);
    localparam fb_pos_t Y_MAX = fb_pos_t'(`FB_HEIGHT - 1);

    draw_state_t state;
    cidx_t       bg_q;    // captured indices
    cidx_t       box_q;

    assign busy     = (state != IDLE);
    assign wr_valid = busy && (state != WAIT_FRAME);
    assign wr_cidx  = (state == CLEAR) ? bg_q : box_q;

    always_ff @(posedge clk_pix) begin
        if (state == IDLE && start) begin
            bg_q  <= bg_cidx;
            box_q <= box_cidx;
        end
    end

    // position moves only on an accepted write
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            wr_x  <= '0;
            wr_y  <= '0;
        end else begin
            case (state)
                IDLE: if (start) state <= WAIT_FRAME;
                WAIT_FRAME:
                    if (frame) begin
                        wr_x  <= '0;
                        wr_y  <= '0;
                        state <= CLEAR;
                    end
                CLEAR:
                    if (wr_ready) begin
                        if (wr_x == X_MAX) begin
                            wr_x <= '0;
                            if (wr_y == Y_MAX) begin
                                wr_y  <= '0;
                                state <= TOP;   // corner (0,0) starts the border
                            end else begin
                                wr_y <= wr_y + 1'b1;
                            end
                        end else begin
                            wr_x <= wr_x + 1'b1;
                        end
                    end
                TOP:
                    if (wr_ready) begin
                        if (wr_x == X_MAX) begin
                            wr_y  <= 8'd1;
                            state <= RIGHT;
                        end else begin
                            wr_x <= wr_x + 1'b1;
                        end
                    end
                RIGHT:
                    if (wr_ready) begin
                        if (wr_y == Y_MAX) begin
                            wr_x  <= X_MAX - 1'b1;
                            state <= BOTTOM;
                        end else begin
                            wr_y <= wr_y + 1'b1;
                        end
                    end
                BOTTOM:
                    if (wr_ready) begin
                        if (wr_x == '0) begin
                            wr_y  <= Y_MAX - 1'b1;
                            state <= LEFT;
                        end else begin
                            wr_x <= wr_x - 1'b1;
                        end
                    end
                LEFT:
                    if (wr_ready) begin
                        if (wr_y == 8'd1) begin
                            state <= IDLE;   // last border pixel
                        end else begin
                            wr_y <= wr_y - 1'b1;
                        end
                    end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/video_top.sv
// display subsystem top: timing generator, framebuffer, box drawer
// and the sync pipeline matching the framebuffer read latency

`timescale 1ns/1ps
`include "video_config.svh"

module video_top import video_pkg::*, fb_pkg::*; (
    input  logic  clk_pix,
    input  logic  arst_n,
    input  logic  draw_start,
    input  cidx_t bg_cidx,
    input  cidx_t box_cidx,
    input  logic  pal_valid,
    input  cidx_t pal_idx,
    input  chan_t pal_r,
    input  chan_t pal_g,
    input  chan_t pal_b,
    output logic  pal_ready,
    output logic  draw_busy,
    output logic  dvi_hsync,
    output logic  dvi_vsync,
    output logic  dvi_de,
    output chan_t dvi_r,
    output chan_t dvi_g,
    output chan_t dvi_b
);

    coord_t  sx;
    coord_t  sy;
    logic    hsync;
    logic    vsync;
    logic    de;
    logic    frame;
    logic    wr_valid;
    logic    wr_ready;
    fb_pos_t wr_x;
    fb_pos_t wr_y;
    cidx_t   wr_cidx;

    // line strobe has no user here
    display_timings u_timings (
        .clk_pix, .arst_n,
        .sx, .sy, .hsync, .vsync, .de, .frame,
        .line()
    );

    framebuffer u_fb (
        .clk_pix, .arst_n,
        .de, .sx, .sy,
        .wr_valid, .wr_x, .wr_y, .wr_cidx, .wr_ready,
        .pal_valid, .pal_idx, .pal_r, .pal_g, .pal_b, .pal_ready,
        .red(dvi_r), .green(dvi_g), .blue(dvi_b)
    );

    box_drawer u_draw (
        .clk_pix, .arst_n,
        .start(draw_start), .bg_cidx, .box_cidx, .frame,
        .busy(draw_busy),
        .wr_valid, .wr_x, .wr_y, .wr_cidx, .wr_ready
    );

    // framebuffer output is two cycles behind the counters
    logic hsync_p1, vsync_p1, de_p1;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync_p1  <= 1'b1;   // syncs idle high
            vsync_p1  <= 1'b1;
            de_p1     <= 1'b0;
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
        end else begin
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            de_p1     <= de;
            dvi_hsync <= hsync_p1;
            dvi_vsync <= vsync_p1;
            dvi_de    <= de_p1;
        end
    end

endmodule

// File: tests/tb_clock.sv
// testbench clock and reset source
// 4 ns pixel clock, reset held low for the first 8 rising edges

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_pix,
    output logic arst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #(PERIOD_NS / 2) clk_pix = ~clk_pix;
    end

    // release just after an edge, like the other driven inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 arst_n = 1'b1;
    end

endmodule

// File: tests/video_top_tb.sv
// video_top testbench: reset, timing, palette load, box drawing,
// redraw under back-pressure and palette update, with a pixel checker

`timescale 1ns/1ps
`include "video_config.svh"

module video_top_tb import video_pkg::*, fb_pkg::*;;

    localparam int LINE_CYCLES    = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int FRAME_LINES    = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int FRAME_CYCLES   = LINE_CYCLES * FRAME_LINES;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 2000;

    logic  clk_pix, arst_n;
    logic  draw_start, pal_valid, pal_ready, draw_busy;
    cidx_t bg_cidx, box_cidx, pal_idx;
    chan_t pal_r, pal_g, pal_b;
    logic  dvi_hsync, dvi_vsync, dvi_de;
    chan_t dvi_r, dvi_g, dvi_b;

    logic [11:0] pal_model [`PAL_DEPTH];   // expected palette contents
    cidx_t       bg_model, box_model;
    int          cycle, errors, err_mark, tests_run, tests_bad;
    int          pal_accepts, acc_base, pix_checked, pix_base;
    int          ox, oy, t0, lines, vs_width;
    logic        de_prev, de_seen, check_en;
    string       chk_name;
    cidx_t       new_bg, new_box;
    logic [11:0] new_val;

    tb_clock u_clock (.clk_pix, .arst_n);

    video_top u_dut (
        .clk_pix, .arst_n, .draw_start, .bg_cidx, .box_cidx,
        .pal_valid, .pal_idx, .pal_r, .pal_g, .pal_b, .pal_ready,
        .draw_busy, .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

    // border of the framebuffer in the box colour, the rest background
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int fx;
        int fy;
        fx = x / `FB_SCALE;
        fy = y / `FB_SCALE;
        if (fx == 0 || fx == `FB_WIDTH - 1 || fy == 0 || fy == `FB_HEIGHT - 1) begin
            return pal_model[box_model];
        end
        return pal_model[bg_model];
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAIL %s: expected %0d (0x%0h) actual %0d (0x%0h)",
                 name, exp, exp, act, act);
        errors++;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            $display("%-24s ok", name);
        end else begin
            $display("%-24s %0d errors", name, errors - err_mark);
            tests_bad++;
        end
        tests_run++;
        err_mark = errors;
    endtask

    task automatic check_idle_outputs(input string name);
        if (dvi_hsync !== 1'b1) report_mismatch({name, " hsync"}, 1, dvi_hsync);
        if (dvi_vsync !== 1'b1) report_mismatch({name, " vsync"}, 1, dvi_vsync);
        if (dvi_de !== 1'b0) report_mismatch({name, " de"}, 0, dvi_de);
        if ({dvi_r, dvi_g, dvi_b} !== 12'h000) begin
            report_mismatch({name, " rgb"}, 0, {dvi_r, dvi_g, dvi_b});
        end
        if (draw_busy !== 1'b0) report_mismatch({name, " draw_busy"}, 0, draw_busy);
        if (pal_ready !== 1'b1) report_mismatch({name, " pal_ready"}, 1, pal_ready);
    endtask

    // hold pal_valid until the framebuffer takes the entry
    task automatic write_pal(input cidx_t idx, input logic [11:0] rgb);
        @(posedge clk_pix);
        #1;
        pal_valid = 1'b1;
        pal_idx   = idx;
        {pal_r, pal_g, pal_b} = rgb;
        @(negedge clk_pix);
        while (!pal_ready) @(negedge clk_pix);
        @(posedge clk_pix);
        #1;
        pal_valid = 1'b0;
    endtask

    task automatic run_draw(input string name, input cidx_t bg, input cidx_t box);
        int t_rise;
        @(posedge clk_pix);
        #1;
        bg_cidx    = bg;
        box_cidx   = box;
        draw_start = 1'b1;
        @(negedge clk_pix);
        while (!draw_busy) @(negedge clk_pix);
        t_rise = cycle;
        @(posedge clk_pix);
        #1;
        draw_start = 1'b0;   // one request only
        @(negedge clk_pix);
        while (draw_busy) @(negedge clk_pix);
        if (cycle - t_rise > 3 * FRAME_CYCLES) begin
            $display("%s: draw_busy stayed high for %0d cycles, over 3 frames",
                     name, cycle - t_rise);
            errors++;
        end
        bg_model  = bg;
        box_model = box;
    endtask

    // enable the checker from one vsync to the next, a whole frame
    task automatic check_frame(input string name);
        @(negedge clk_pix);
        while (dvi_vsync) @(negedge clk_pix);
        @(posedge clk_pix);
        #1;
        chk_name = name;
        pix_base = pix_checked;
        check_en = 1'b1;
        @(negedge clk_pix);
        while (!dvi_vsync) @(negedge clk_pix);
        while (dvi_vsync) @(negedge clk_pix);
        @(posedge clk_pix);
        #1;
        check_en = 1'b0;
        if (pix_checked - pix_base != `H_ACTIVE * `V_ACTIVE) begin
            report_mismatch({name, " pixel count"}, `H_ACTIVE * `V_ACTIVE,
                            pix_checked - pix_base);
        end
    endtask

    always @(posedge clk_pix) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clk_pix) begin
        if (pal_valid && pal_ready) pal_accepts++;   // taken on the next edge
    end

    // output position tracking and pixel compare
    always @(negedge clk_pix) begin
        if (dvi_de) begin
            if (check_en) begin
                pix_checked++;
                if ({dvi_r, dvi_g, dvi_b} !== expected_rgb(ox, oy)) begin
                    report_mismatch($sformatf("%s pixel (%0d,%0d)", chk_name, ox, oy),
                                    expected_rgb(ox, oy), {dvi_r, dvi_g, dvi_b});
                end
            end
            ox++;
        end else begin
            if (check_en && {dvi_r, dvi_g, dvi_b} !== 12'h000) begin
                report_mismatch({chk_name, " blanking rgb"}, 0, {dvi_r, dvi_g, dvi_b});
            end
            if (de_prev) begin   // end of an active line
                oy++;
                ox = 0;
            end
        end
        if (!dvi_vsync) begin
            ox = 0;
            oy = 0;
        end
        de_prev = dvi_de;
    end

    initial begin
        draw_start = 1'b0;
        bg_cidx    = '0;
        box_cidx   = '0;
        pal_valid  = 1'b0;
        pal_idx    = '0;
        pal_r      = '0;
        pal_g      = '0;
        pal_b      = '0;
        check_en   = 1'b0;
        de_prev    = 1'b0;
        void'($urandom(32'hed25_2687));

        // reset values, in reset and just after release
        repeat (3) @(negedge clk_pix);
        check_idle_outputs("reset asserted");
        @(posedge arst_n);
        @(negedge clk_pix);
        check_idle_outputs("reset released");
        finish_test("reset state");

        // line timing
        while (!dvi_hsync) @(negedge clk_pix);
        while (dvi_hsync) @(negedge clk_pix);
        t0 = cycle;
        while (!dvi_hsync) @(negedge clk_pix);
        if (cycle - t0 != `H_SYNC) report_mismatch("timing hsync width", `H_SYNC, cycle - t0);
        while (dvi_hsync) @(negedge clk_pix);
        if (cycle - t0 != LINE_CYCLES) begin
            report_mismatch("timing line period", LINE_CYCLES, cycle - t0);
        end
        while (!dvi_de) @(negedge clk_pix);
        t0 = cycle;
        while (dvi_de) @(negedge clk_pix);
        if (cycle - t0 != `H_ACTIVE) report_mismatch("timing de per line", `H_ACTIVE, cycle - t0);

        // frame timing, from one vsync fall to the next
        while (dvi_vsync) @(negedge clk_pix);
        t0      = cycle;
        lines   = 0;
        de_seen = 1'b0;
        while (!dvi_vsync) @(negedge clk_pix);
        vs_width = cycle - t0;
        while (dvi_vsync) begin
            if (dvi_de && !de_seen) lines++;
            de_seen = dvi_de;
            @(negedge clk_pix);
        end
        if (vs_width != `V_SYNC * LINE_CYCLES) begin
            report_mismatch("timing vsync width", `V_SYNC * LINE_CYCLES, vs_width);
        end
        if (lines != `V_ACTIVE) report_mismatch("timing active lines", `V_ACTIVE, lines);
        if (cycle - t0 != FRAME_CYCLES) begin
            report_mismatch("timing frame period", FRAME_CYCLES, cycle - t0);
        end
        finish_test("video timing");

        // load during active video so the port stalls after each fetch
        while (!dvi_de) @(negedge clk_pix);
        acc_base = pal_accepts;
        for (int i = 0; i < `PAL_DEPTH; i++) begin
            pal_model[i] = $urandom % 4096;
            write_pal(cidx_t'(i), pal_model[i]);
        end
        if (pal_accepts - acc_base != `PAL_DEPTH) begin
            report_mismatch("palette accepted writes", `PAL_DEPTH, pal_accepts - acc_base);
        end
        finish_test("palette load");

        do begin
            new_bg  = $urandom % `PAL_DEPTH;
            new_box = $urandom % `PAL_DEPTH;
        end while (new_bg == new_box);
        run_draw("box drawing", new_bg, new_box);
        check_frame("box drawing");
        finish_test("box drawing");

        // new indices, so any lost write leaves an old colour behind
        do begin
            new_bg  = $urandom % `PAL_DEPTH;
            new_box = $urandom % `PAL_DEPTH;
        end while (new_bg == new_box || new_bg == bg_model || new_box == box_model);
        run_draw("redraw", new_bg, new_box);
        check_frame("redraw");
        finish_test("redraw back-pressure");

        // background entry rewritten in the middle of the active area
        @(negedge clk_pix);
        while (!dvi_vsync) @(negedge clk_pix);
        repeat (20 * LINE_CYCLES) @(posedge clk_pix);
        do begin
            new_val = $urandom % 4096;
        end while (new_val == pal_model[bg_model]);
        write_pal(bg_model, new_val);
        pal_model[bg_model] = new_val;
        check_frame("palette update");
        finish_test("palette update");

        $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/video_pkg.sv
design/fb_pkg.sv
design/display_timings.sv
design/framebuffer.sv
design/box_drawer.sv
design/video_top.sv
tests/tb_clock.sv
tests/video_top_tb.sv
